// File: hw/tawas_pkg.sv
package tawas_pkg;

  // Address and data widths of the core
  localparam int IADDR_W   = 24;
  localparam int DADDR_W   = 16;
  localparam int DATA_W    = 32;
  localparam int NUM_REGS  = 8;
  localparam int REG_IDX_W = $clog2(NUM_REGS);
  localparam int LINK_REG  = 7;
  localparam int IMM_W     = 25;
  localparam int FLAG_W    = 16;
  localparam int SHAMT_W   = $clog2(DATA_W);
  localparam int OFFSET_W  = 8;

  // Instruction word classes, taken from the top bits of the word
  localparam logic [1:0] CLS_SER_AU = 2'b00;
  localparam logic [1:0] CLS_SER_LS = 2'b01;
  localparam logic [1:0] CLS_PAIR   = 2'b10;
  localparam logic [3:0] CLS_BR_AU  = 4'b1100;
  localparam logic [3:0] CLS_BR_LS  = 4'b1101;
  localparam logic [3:0] CLS_IMM    = 4'b1110;
  localparam logic [3:0] CLS_JMP    = 4'b1111;

  // AU function codes
  localparam logic [2:0] AU_ADD = 3'd0;
  localparam logic [2:0] AU_SUB = 3'd1;
  localparam logic [2:0] AU_AND = 3'd2;
  localparam logic [2:0] AU_OR  = 3'd3;
  localparam logic [2:0] AU_XOR = 3'd4;
  localparam logic [2:0] AU_SHL = 3'd5;
  localparam logic [2:0] AU_SHR = 3'd6;
  localparam logic [2:0] AU_MOV = 3'd7;

  // Bit positions in the flag word; the upper bits read as zero
  localparam int FLAG_ONE    = 0;
  localparam int FLAG_ZERO   = 1;
  localparam int FLAG_NEG    = 2;
  localparam int FLAG_CARRY  = 3;
  localparam int FLAG_NZERO  = 4;
  localparam int FLAG_NNEG   = 5;
  localparam int FLAG_NCARRY = 6;

  typedef struct packed {
    logic [2:0]           func;
    logic [REG_IDX_W-1:0] rd;
    logic [REG_IDX_W-1:0] ra;
    logic [REG_IDX_W-1:0] rb;
    logic [2:0]           spare;
  } au_op_t;

  // Offset is an unsigned word offset added to the base register
  typedef struct packed {
    logic                 store;
    logic [REG_IDX_W-1:0] reg_idx;
    logic [REG_IDX_W-1:0] base;
    logic [OFFSET_W-1:0]  offset;
  } ls_op_t;

  typedef struct packed {
    logic [REG_IDX_W-1:0] rd;
    logic [IMM_W-1:0]     value;
  } au_imm_t;

  typedef struct packed {
    logic               slice;
    logic               au_vld;
    au_op_t             au_op;
    logic               imm_vld;
    au_imm_t            au_imm;
    logic               ls_vld;
    ls_op_t             ls_op;
    logic               link_vld;
    logic [IADDR_W-1:0] link_value;
  } issue_t;

  typedef struct packed {
    logic                 en;
    logic                 slice;
    logic [REG_IDX_W-1:0] idx;
    logic [DATA_W-1:0]    data;
  } wr_port_t;

endpackage

// File: hw/tawas_fetch.sv
`timescale 1ns/1ps

module tawas_fetch
  import tawas_pkg::*;
(
  input  logic               CLK,
  input  logic               RST,
  output logic [IADDR_W-1:0] I_ADDR,
  input  logic [DATA_W-1:0]  I_DATA,
  input  logic [FLAG_W-1:0]  FLAGS,
  input  logic [IADDR_W-1:0] LINK,
  output issue_t             ISSUE
);

  // Slice that owns the word on I_DATA in this cycle
  logic               slice;
  // Next fetch address of each slice, kept while the other slice runs
  logic [IADDR_W-1:0] pc_0;
  logic [IADDR_W-1:0] pc_1;
  // Set while a slice still owes the upper half of a series word
  logic               ser_0;
  logic               ser_1;
  logic               ser_cur;

  logic [1:0]         top2;
  logic [3:0]         top4;
  logic               is_series;
  logic               is_br;
  logic               is_jmp;
  logic [3:0]         cond_sel;
  logic               cond_true;
  logic [IADDR_W-1:0] pc_inc;
  logic [IADDR_W-1:0] jmp_tgt;
  logic [IADDR_W-1:0] pc_next;

  assign top2      = I_DATA[31:30];
  assign top4      = I_DATA[31:28];
  assign is_series = (top2 == CLS_SER_AU) || (top2 == CLS_SER_LS);
  assign is_br     = (top4 == CLS_BR_AU) || (top4 == CLS_BR_LS);
  assign is_jmp    = (top4 == CLS_JMP);
  assign ser_cur   = slice ? ser_1 : ser_0;

  // I_ADDR always holds the counter of the slice in its turn
  assign pc_inc = I_ADDR + 1'b1;

  // Only a conditional short branch looks at a real flag
  // Every other word selects flag 0, which is always set
  always_comb
  begin
    cond_sel = 4'd0;
    if (is_br && !I_DATA[27])
      cond_sel = I_DATA[26:23];
    cond_true = FLAGS[cond_sel];
  end

  always_comb
  begin
    // Return takes the link register, otherwise the word holds the target
    jmp_tgt = I_DATA[25] ? LINK : I_DATA[23:0];
    if (is_series && !ser_cur)
      // First half of a series word, so fetch the same word again
      pc_next = I_ADDR;
    else if (is_jmp)
      pc_next = I_DATA[24] ? (I_ADDR + jmp_tgt) : jmp_tgt;
    else if (is_br && I_DATA[27])
      pc_next = I_ADDR + {{12{I_DATA[26]}}, I_DATA[26:15]};
    else if (is_br && cond_true)
      pc_next = I_ADDR + {{16{I_DATA[22]}}, I_DATA[22:15]};
    else
      pc_next = pc_inc;
  end

  // Slices alternate each clock, so the address presented next
  // is the stored counter of the other slice
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      slice  <= 1'b0;
      I_ADDR <= '0;
      pc_0   <= '0;
      pc_1   <= 24'd1;
      ser_0  <= 1'b0;
      ser_1  <= 1'b0;
    end
    else
    begin
      slice <= ~slice;
      if (!slice)
      begin
        pc_0   <= pc_next;
        ser_0  <= is_series && !ser_0;
        I_ADDR <= pc_1;
      end
      else
      begin
        pc_1   <= pc_next;
        ser_1  <= is_series && !ser_1;
        I_ADDR <= pc_0;
      end
    end
  end

  // Opcode picking; a pair word carries its LS op in the upper half
  always_comb
  begin
    ISSUE.slice      = slice;
    ISSUE.au_vld     = (top2 == CLS_SER_AU) || (top2 == CLS_PAIR) || (top4 == CLS_BR_AU);
    ISSUE.au_op      = ser_cur ? I_DATA[29:15] : I_DATA[14:0];
    ISSUE.imm_vld    = (top4 == CLS_IMM);
    ISSUE.au_imm     = I_DATA[27:0];
    ISSUE.ls_vld     = (top2 == CLS_SER_LS) || (top2 == CLS_PAIR) || (top4 == CLS_BR_LS);
    ISSUE.ls_op      = (ser_cur || (top2 == CLS_PAIR)) ? I_DATA[29:15] : I_DATA[14:0];
    // A call saves the address after the jump word
    ISSUE.link_vld   = is_jmp && I_DATA[26];
    ISSUE.link_value = pc_inc;
  end

  // The second turn of a series word must see the same series word again
  a_series_word : assert property (@(posedge CLK) disable iff (RST)
    ser_cur |-> !I_DATA[31]);

  a_slice_toggle : assert property (@(posedge CLK) disable iff (RST)
    !$past(RST) |-> (slice != $past(slice)));

endmodule

// File: hw/tawas_au.sv
`timescale 1ns/1ps

module tawas_au
  import tawas_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  issue_t               ISSUE,
  output logic [REG_IDX_W-1:0] RD_A,
  output logic [REG_IDX_W-1:0] RD_B,
  input  logic [DATA_W-1:0]    OPA,
  input  logic [DATA_W-1:0]    OPB,
  output logic [FLAG_W-1:0]    FLAGS,
  output wr_port_t             WR
);

  au_op_t            op;
  logic [DATA_W-1:0] result;
  logic              carry;
  logic [DATA_W-1:0] imm_ext;

  // Condition state, one bit per slice
  logic [1:0]        zero_q;
  logic [1:0]        neg_q;
  logic [1:0]        carry_q;

  assign op   = ISSUE.au_op;
  assign RD_A = op.ra;
  assign RD_B = op.rb;

  // Carry is the carry out of ADD and the borrow of SUB
  always_comb
  begin
    carry  = 1'b0;
    result = '0;
    case (op.func)
      AU_ADD: {carry, result} = {1'b0, OPA} + {1'b0, OPB};
      AU_SUB: {carry, result} = {1'b0, OPA} - {1'b0, OPB};
      AU_AND: result = OPA & OPB;
      AU_OR:  result = OPA | OPB;
      AU_XOR: result = OPA ^ OPB;
      AU_SHL: result = OPA << OPB[SHAMT_W-1:0];
      AU_SHR: result = OPA >> OPB[SHAMT_W-1:0];
      default: result = OPA;
    endcase
  end

  assign imm_ext = {{(DATA_W-IMM_W){ISSUE.au_imm.value[IMM_W-1]}}, ISSUE.au_imm.value};

  // Register write takes effect on the issue edge
  always_comb
  begin
    WR.en    = ISSUE.au_vld || ISSUE.imm_vld;
    WR.slice = ISSUE.slice;
    WR.idx   = ISSUE.imm_vld ? ISSUE.au_imm.rd : op.rd;
    WR.data  = ISSUE.imm_vld ? imm_ext : result;
  end

  // Only register ops touch the flags, immediate loads leave them alone
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      zero_q  <= '0;
      neg_q   <= '0;
      carry_q <= '0;
    end
    else if (ISSUE.au_vld)
    begin
      zero_q[ISSUE.slice]  <= (result == '0);
      neg_q[ISSUE.slice]   <= result[DATA_W-1];
      carry_q[ISSUE.slice] <= carry;
    end
  end

  // Flag word of the slice in its turn, with the inverted copies
  // that let a branch test either sense
  always_comb
  begin
    FLAGS              = '0;
    FLAGS[FLAG_ONE]    = 1'b1;
    FLAGS[FLAG_ZERO]   = zero_q[ISSUE.slice];
    FLAGS[FLAG_NEG]    = neg_q[ISSUE.slice];
    FLAGS[FLAG_CARRY]  = carry_q[ISSUE.slice];
    FLAGS[FLAG_NZERO]  = !zero_q[ISSUE.slice];
    FLAGS[FLAG_NNEG]   = !neg_q[ISSUE.slice];
    FLAGS[FLAG_NCARRY] = !carry_q[ISSUE.slice];
  end

  // Fetch never issues a register op and an immediate in one word
  a_one_au_op : assert property (@(posedge CLK) disable iff (RST)
    !(ISSUE.au_vld && ISSUE.imm_vld));

endmodule

// File: hw/tawas_ls.sv
`timescale 1ns/1ps

module tawas_ls
  import tawas_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  issue_t               ISSUE,
  output logic [REG_IDX_W-1:0] RD_BASE,
  output logic [REG_IDX_W-1:0] RD_DATA,
  input  logic [DATA_W-1:0]    BASE,
  input  logic [DATA_W-1:0]    SDATA,
  output logic [DADDR_W-1:0]   D_ADDR,
  output logic                 D_WR,
  output logic [DATA_W-1:0]    D_WDATA,
  output logic                 D_RD,
  input  logic [DATA_W-1:0]    D_RDATA,
  output wr_port_t             WR
);

  ls_op_t               op;
  // One load in flight, waiting for its data
  logic                 pend_vld;
  logic                 pend_slice;
  logic [REG_IDX_W-1:0] pend_idx;

  assign op      = ISSUE.ls_op;
  assign RD_BASE = op.base;
  assign RD_DATA = op.reg_idx;

  // Word address from the low bits of the base plus the offset
  assign D_ADDR  = BASE[DADDR_W-1:0] + {{(DADDR_W-OFFSET_W){1'b0}}, op.offset};
  assign D_WR    = ISSUE.ls_vld && op.store;
  assign D_RD    = ISSUE.ls_vld && !op.store;
  assign D_WDATA = SDATA;

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      pend_vld <= 1'b0;
    else
      pend_vld <= D_RD;
  end

  always_ff @(posedge CLK)
  begin
    if (D_RD)
    begin
      pend_slice <= ISSUE.slice;
      pend_idx   <= op.reg_idx;
    end
  end

  // Read data arrives one cycle after D_RD and is written at the end of it
  assign WR.en    = pend_vld;
  assign WR.slice = pend_slice;
  assign WR.idx   = pend_idx;
  assign WR.data  = D_RDATA;

  a_wr_rd_excl : assert property (@(posedge CLK) disable iff (RST)
    !(D_WR && D_RD));

endmodule

// File: hw/tawas_regfile.sv
`timescale 1ns/1ps

module tawas_regfile
  import tawas_pkg::*;
(
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 SLICE,
  input  logic [REG_IDX_W-1:0] AU_A,
  input  logic [REG_IDX_W-1:0] AU_B,
  input  logic [REG_IDX_W-1:0] LS_BASE,
  input  logic [REG_IDX_W-1:0] LS_DATA,
  output logic [DATA_W-1:0]    AU_A_VAL,
  output logic [DATA_W-1:0]    AU_B_VAL,
  output logic [DATA_W-1:0]    LS_BASE_VAL,
  output logic [DATA_W-1:0]    LS_DATA_VAL,
  output logic [IADDR_W-1:0]   LINK,
  input  wr_port_t             AU_WR,
  input  wr_port_t             LS_WR,
  input  logic                 LINK_WR_EN,
  input  logic                 LINK_WR_SLICE,
  input  logic [IADDR_W-1:0]   LINK_WR_DATA
);

  logic [DATA_W-1:0] bank [2][NUM_REGS];
  // All three writers in one form: AU, LS, then link
  wr_port_t          wr_ports [3];

  function automatic logic clash(input wr_port_t a, input wr_port_t b);
    clash = a.en && b.en && (a.slice == b.slice) && (a.idx == b.idx);
  endfunction

  assign wr_ports[0]       = AU_WR;
  assign wr_ports[1]       = LS_WR;
  assign wr_ports[2].en    = LINK_WR_EN;
  assign wr_ports[2].slice = LINK_WR_SLICE;
  assign wr_ports[2].idx   = REG_IDX_W'(LINK_REG);
  assign wr_ports[2].data  = {{(DATA_W-IADDR_W){1'b0}}, LINK_WR_DATA};

  // Reads come from the bank of the slice in its turn
  assign AU_A_VAL    = bank[SLICE][AU_A];
  assign AU_B_VAL    = bank[SLICE][AU_B];
  assign LS_BASE_VAL = bank[SLICE][LS_BASE];
  assign LS_DATA_VAL = bank[SLICE][LS_DATA];
  assign LINK        = bank[SLICE][LINK_REG][IADDR_W-1:0];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int s = 0; s < 2; s++)
        for (int r = 0; r < NUM_REGS; r++)
          bank[s][r] <= '0;
    end
    else
    begin
      for (int p = 0; p < 3; p++)
        if (wr_ports[p].en)
          bank[wr_ports[p].slice][wr_ports[p].idx] <= wr_ports[p].data;
    end
  end

  // Slice interleaving keeps the writers apart in every edge
  a_no_clash : assert property (@(posedge CLK) disable iff (RST)
    !(clash(wr_ports[0], wr_ports[1]) || clash(wr_ports[0], wr_ports[2]) ||
      clash(wr_ports[1], wr_ports[2])));

endmodule

// File: hw/tawas_top.sv
`timescale 1ns/1ps

module tawas_top
  import tawas_pkg::*;
(
  input  logic               CLK,
  input  logic               RST,
  output logic [IADDR_W-1:0] I_ADDR,
  input  logic [DATA_W-1:0]  I_DATA,
  output logic [DADDR_W-1:0] D_ADDR,
  output logic               D_WR,
  output logic [DATA_W-1:0]  D_WDATA,
  output logic               D_RD,
  input  logic [DATA_W-1:0]  D_RDATA
);

  issue_t               issue;
  logic [FLAG_W-1:0]    flags;
  logic [IADDR_W-1:0]   link;
  logic [REG_IDX_W-1:0] au_rd_a;
  logic [REG_IDX_W-1:0] au_rd_b;
  logic [REG_IDX_W-1:0] ls_rd_base;
  logic [REG_IDX_W-1:0] ls_rd_data;
  logic [DATA_W-1:0]    au_opa;
  logic [DATA_W-1:0]    au_opb;
  logic [DATA_W-1:0]    ls_base;
  logic [DATA_W-1:0]    ls_sdata;
  wr_port_t             au_wr;
  wr_port_t             ls_wr;

  // Decode stage, feeds every other block
  tawas_fetch u_fetch (
    .CLK    (CLK),
    .RST    (RST),
    .I_ADDR (I_ADDR),
    .I_DATA (I_DATA),
    .FLAGS  (flags),
    .LINK   (link),
    .ISSUE  (issue)
  );

  tawas_au u_au (
    .CLK   (CLK),
    .RST   (RST),
    .ISSUE (issue),
    .RD_A  (au_rd_a),
    .RD_B  (au_rd_b),
    .OPA   (au_opa),
    .OPB   (au_opb),
    .FLAGS (flags),
    .WR    (au_wr)
  );

  tawas_ls u_ls (
    .CLK     (CLK),
    .RST     (RST),
    .ISSUE   (issue),
    .RD_BASE (ls_rd_base),
    .RD_DATA (ls_rd_data),
    .BASE    (ls_base),
    .SDATA   (ls_sdata),
    .D_ADDR  (D_ADDR),
    .D_WR    (D_WR),
    .D_WDATA (D_WDATA),
    .D_RD    (D_RD),
    .D_RDATA (D_RDATA),
    .WR      (ls_wr)
  );

  // Call writes the link register directly from the decode stage
  tawas_regfile u_regfile (
    .CLK           (CLK),
    .RST           (RST),
    .SLICE         (issue.slice),
    .AU_A          (au_rd_a),
    .AU_B          (au_rd_b),
    .LS_BASE       (ls_rd_base),
    .LS_DATA       (ls_rd_data),
    .AU_A_VAL      (au_opa),
    .AU_B_VAL      (au_opb),
    .LS_BASE_VAL   (ls_base),
    .LS_DATA_VAL   (ls_sdata),
    .LINK          (link),
    .AU_WR         (au_wr),
    .LS_WR         (ls_wr),
    .LINK_WR_EN    (issue.link_vld),
    .LINK_WR_SLICE (issue.slice),
    .LINK_WR_DATA  (issue.link_value)
  );

endmodule

// File: testbench/tb_tawas.sv
`timescale 1ns/1ps

module tb_tawas
  import tawas_pkg::*;
();

  localparam int ROM_WORDS  = 256;
  localparam int RAM_WORDS  = 256;
  localparam int MAX_STORES = 16;
  // The program settles in well under 100 cycles, so 400 leaves a wide margin
  localparam int TIMEOUT_CYCLES = 400;
  // Extra cycles after the last store to catch any store that should not happen
  localparam int DRAIN_CYCLES = 20;
  localparam logic [31:0] LCG_SEED = 32'd57;
  // Slice 0 stores below this address and slice 1 stores at or above it
  localparam logic [DADDR_W-1:0] SLICE1_BASE = 16'h0040;
  // Slice 1 reads the LCG words from here on, one load per word
  localparam logic [DADDR_W-1:0] LCG_ADDR  = 16'h0080;
  localparam int                 NUM_LOADS = 4;

  logic                CLK = 1'b0;
  logic                RST = 1'b1;
  logic [IADDR_W-1:0]  instr_addr;
  logic [DATA_W-1:0]   instr_data;
  logic [DADDR_W-1:0]  data_addr;
  logic                data_wr;
  logic [DATA_W-1:0]   data_wdata;
  logic                data_rd;
  logic [DATA_W-1:0]   data_rdata = '0;

  logic [DATA_W-1:0]   rom [ROM_WORDS];
  logic [DATA_W-1:0]   ram [RAM_WORDS];
  logic [DATA_W-1:0]   lcg_word [4];

  // Expected store sequence of each slice, in program order
  logic [DADDR_W-1:0]  exp0_addr [MAX_STORES];
  logic [DATA_W-1:0]   exp0_data [MAX_STORES];
  logic [DADDR_W-1:0]  exp1_addr [MAX_STORES];
  logic [DATA_W-1:0]   exp1_data [MAX_STORES];
  int                  n0 = 0;
  int                  n1 = 0;
  int                  ptr0 = 0;
  int                  ptr1 = 0;
  int                  loads = 0;
  int                  cyc = 0;
  int                  check_errors = 0;

  logic                exp_have;
  logic [DADDR_W-1:0]  exp_addr;
  logic [DATA_W-1:0]   exp_data;
  logic                store_ok;

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Slice 0 code lives at 0x10 to 0x3F, slice 1 code and its subroutine at 0x40 to 0x7F
  function automatic logic in_slice_range(input logic slice, input logic [IADDR_W-1:0] addr);
    if (slice)
      return (addr >= 24'h40) && (addr < 24'h80);
    return (addr >= 24'h10) && (addr < 24'h40);
  endfunction

  task automatic expect_store(input logic slice, input logic [DADDR_W-1:0] addr,
                              input logic [DATA_W-1:0] data);
    if (slice)
    begin
      exp1_addr[n1] = addr;
      exp1_data[n1] = data;
      n1++;
    end
    else
    begin
      exp0_addr[n0] = addr;
      exp0_data[n0] = data;
      n0++;
    end
  endtask

  task automatic report_check(input string msg);
    check_errors++;
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
  endtask

  task automatic report_store(input logic [DADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input logic have, input logic [DADDR_W-1:0] e_addr,
                              input logic [DATA_W-1:0] e_data);
    if (have)
      report_check($sformatf("store of %h to %h, expected %h to %h", data, addr, e_data, e_addr));
    else
      report_check($sformatf("store of %h to %h was not expected at all", data, addr));
  endtask

  tawas_top UUT (
    .CLK     (CLK),
    .RST     (RST),
    .I_ADDR  (instr_addr),
    .I_DATA  (instr_data),
    .D_ADDR  (data_addr),
    .D_WR    (data_wr),
    .D_WDATA (data_wdata),
    .D_RD    (data_rd),
    .D_RDATA (data_rdata)
  );

  always #10 CLK = ~CLK;

  // Combinational instruction ROM
  assign instr_data = rom[instr_addr[7:0]];

  // Data RAM writes on the issue edge and returns read data one cycle later
  always @(posedge CLK)
  begin
    if (RST)
    begin
      for (int a = 0; a < RAM_WORDS; a++)
        if ((a >= 'h80) && (a < 'h84))
          ram[a] <= lcg_word[a - 'h80];
        else
          ram[a] <= {16'hDA7A, 16'(a)};
      data_rdata <= '0;
    end
    else
    begin
      if (data_wr)
        ram[data_addr[7:0]] <= data_wdata;
      if (data_rd)
        data_rdata <= ram[data_addr[7:0]];
    end
  end

  // Counts active edges, so cyc 0 is the edge that ends the fetch of word 0
  always @(posedge CLK)
  begin
    if (!RST)
      cyc <= cyc + 1;
  end

  // Each store moves the pointer of the slice that owns its address range
  always @(posedge CLK)
  begin
    if (!RST && data_wr)
    begin
      if (data_addr < SLICE1_BASE)
        ptr0 <= ptr0 + 1;
      else
        ptr1 <= ptr1 + 1;
    end
  end

  always @(posedge CLK)
  begin
    if (!RST && data_rd)
      loads <= loads + 1;
  end

  always_comb
  begin
    exp_have = 1'b0;
    exp_addr = '0;
    exp_data = '0;
    if (data_addr < SLICE1_BASE)
    begin
      if (ptr0 < n0)
      begin
        exp_have = 1'b1;
        exp_addr = exp0_addr[ptr0];
        exp_data = exp0_data[ptr0];
      end
    end
    else if (ptr1 < n1)
    begin
      exp_have = 1'b1;
      exp_addr = exp1_addr[ptr1];
      exp_data = exp1_data[ptr1];
    end
    store_ok = exp_have && (data_addr == exp_addr) && (data_wdata == exp_data);
  end

  // The first two fetches are the start words of slice 0 and slice 1
  a_first_fetch : assert property (@(posedge CLK) disable iff (RST)
    (cyc < 2) |-> (instr_addr == IADDR_W'(cyc)))
    else report_check($sformatf("fetch %0d went to address %h", $sampled(cyc),
                                $sampled(instr_addr)));

  // After the start jumps the fetch alternates between the two code areas
  a_slice_ranges : assert property (@(posedge CLK) disable iff (RST)
    (cyc >= 2) |-> in_slice_range(cyc[0], instr_addr))
    else report_check($sformatf("fetch %0d at %h is outside the code of slice %0d",
                                $sampled(cyc), $sampled(instr_addr), $sampled(cyc[0])));

  a_store_matches : assert property (@(posedge CLK) disable iff (RST)
    data_wr |-> store_ok)
    else report_store($sampled(data_addr), $sampled(data_wdata), $sampled(exp_have),
                      $sampled(exp_addr), $sampled(exp_data));

  // The series load pairs read the LCG words once each, in address order
  a_load_order : assert property (@(posedge CLK) disable iff (RST)
    data_rd |-> ((loads < NUM_LOADS) && (data_addr == LCG_ADDR + DADDR_W'(loads))))
    else report_check($sformatf("load %0d from %h is out of order or not expected",
                                $sampled(loads), $sampled(data_addr)));

  initial
  begin
    logic [31:0]       state;
    logic [DATA_W-1:0] imm_a;
    logic [DATA_W-1:0] imm_b;
    logic [DATA_W-1:0] lcg_sum;
    logic              timed_out;
    int                missing;

    state   = LCG_SEED;
    lcg_sum = '0;
    for (int i = 0; i < 4; i++)
    begin
      state       = lcg_step(state);
      lcg_word[i] = state;
      lcg_sum     = lcg_sum + state;
    end

    // Unused ROM words jump to themselves, so a stray fetch parks the slice
    for (int a = 0; a < ROM_WORDS; a++)
      rom[a] = {8'hF0, 24'(a)};
    $readmemh("testbench/prog.hex", rom);

    // Immediate 0x12345 is positive, 0x1FFFF0F has bit 24 set and reads back negative
    imm_a = 32'h0001_2345;
    imm_b = 32'hFFFF_FF0F;

    // Slice 0 ALU results, the series pair, the countdown and its marker
    expect_store(1'b0, 16'h0000, imm_a + imm_b);
    expect_store(1'b0, 16'h0001, imm_a - imm_b);
    expect_store(1'b0, 16'h0002, imm_a & imm_b);
    expect_store(1'b0, 16'h0003, imm_a ^ imm_b);
    expect_store(1'b0, 16'h0004, imm_a << 4);
    expect_store(1'b0, 16'h0005, (imm_a + 32'd4) << 4);
    for (int v = 5; v >= 1; v--)
      expect_store(1'b0, 16'h0008, 32'(v));
    expect_store(1'b0, 16'h0009, 32'h0000_00EE);

    // Slice 1 subroutine store, the store after return and the LCG sum
    expect_store(1'b1, 16'h0040, 32'h0000_00A1);
    expect_store(1'b1, 16'h0041, 32'h0000_00A2);
    expect_store(1'b1, 16'h0042, lcg_sum);

    repeat (4) @(posedge CLK);
    RST <= 1'b0;

    while (!((ptr0 == n0) && (ptr1 == n1)) && (cyc < TIMEOUT_CYCLES))
      @(posedge CLK);
    timed_out = (ptr0 != n0) || (ptr1 != n1);
    if (timed_out)
      $display("Timeout after %0d cycles: %0d of %0d slice 0 stores, %0d of %0d slice 1 stores",
               cyc, ptr0, n0, ptr1, n1);
    else
      repeat (DRAIN_CYCLES) @(posedge CLK);

    missing = (n0 - ptr0) + (n1 - ptr1);
    $display("Summary: %0d failed checks, %0d missing stores", check_errors, missing);
    if ((check_errors == 0) && (missing == 0) && !timed_out)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: filelist.f
hw/tawas_pkg.sv
hw/tawas_fetch.sv
hw/tawas_au.sv
hw/tawas_ls.sv
hw/tawas_regfile.sv
hw/tawas_top.sv
testbench/tb_tawas.sv

// File: run_sim.sh
#!/bin/sh
# Build the tawas core testbench with Verilator and run it into a log file

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_tawas -Mdir "$OBJ" -o tb_tawas -f filelist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/tb_tawas" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qF '*** TEST FAILED ***' "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi
echo "Simulation finished without a reported failure"
exit 0

// File: testbench/prog.hex
// Instruction ROM image: @ lines give a word address, then 32-bit hex words in address order
// Words 0 and 1 are the slice start jumps, slice 0 runs from 0x10 and slice 1 from 0x40
@00
F0000010 F0000040
// Slice 0 loads r1, r2, r3 and stores ADD, SUB, AND, XOR and SHL results to 0x00 to 0x04
@10
E2012345 E5FFFF0F E6000004
C8008850 D800E000 C8009850 D800E001
C800A850 D800E002 C800C850 D800E003
C800D858 D800E004
// Series AU pair r5 = (r1 + r3) << r3, stored to 0x05
2DAC0A58 D800E805
// Countdown of r6 from 5 stored to 0x08 on each pass, then marker 0xEE to 0x09 and halt
E4000001 EC000005 D800F008 C8009D90 C27F7000
E80000EE D800E009 F0000026
// Slice 1 call, store of 0xA2 to 0x41, two series load pairs and the sum stored to 0x42
@40
F4000060 E20000A2 D800C841
4C409080 5441A082
C8008C98 C8008DA0 C8008DA8 B8210380 F0000049
// Subroutine stores 0xA1 to 0x40 and returns through the link register
@60
E20000A1 D800C840 F2000000
